//--- sim.f
+incdir+hw
hw/exu_pkg.sv
hw/execute_controller.sv
hw/execute_reg.sv
hw/fu.sv
hw/lsu.sv
hw/execute.sv
verif/tb_execute.sv

//--- Bender.yml
package:
  name: execute

sources:
  - include_dirs:
      - hw
    files:
      - hw/exu_pkg.sv
      - hw/execute_controller.sv
      - hw/execute_reg.sv
      - hw/fu.sv
      - hw/lsu.sv
      - hw/execute.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_execute.sv

//--- verif/tb_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_params.svh"

module tb_execute;

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          MEM_WORDS      = 64;
  localparam logic [31:0] SEED           = 32'h0e8d_74d3;

  logic                       clock;
  logic                       rst_n_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  exu_pkg::exu_in_t           in_i;
  logic                       out_valid_o;
  logic                       out_ready_i;
  exu_pkg::exu_wb_t           wb_o;
  exu_pkg::exu_csr_wb_t       csr_o;
  logic                       awvalid_o, awready_i;
  exu_pkg::axi_aw_t           aw_o;
  logic                       wvalid_o, wready_i;
  exu_pkg::axi_w_t            w_o;
  logic                       bvalid_i, bready_o;
  logic [`EXU_RESP_W-1:0]     bresp_i;
  logic                       arvalid_o, arready_i;
  exu_pkg::axi_ar_t           ar_o;
  logic                       rvalid_i, rready_o;
  logic [`EXU_XLEN-1:0]       rdata_i;
  logic [`EXU_RESP_W-1:0]     rresp_i;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] op_seed;
  logic [31:0] stall_seed;
  int          aw_wait, w_wait, b_wait, ar_wait, r_wait;
  logic        aw_got, w_got, ar_got;
  logic [31:0] aw_addr_q, w_data_q, ar_addr_q;
  logic [3:0]  w_strb_q;
  int          cycle_count = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;

  execute execute_i (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    op_seed = lcg_step(op_seed);
    return op_seed;
  endfunction

  // Stall of 0 to 3 cycles from the upper LCG bits
  function automatic int next_stall();
    stall_seed = lcg_step(stall_seed);
    return int'(stall_seed[17:16]);
  endfunction

  // Bus memory model
  // A ready or valid still high at a falling edge has just completed its handshake
  always @(negedge clock) begin
    if (rst_n_i) begin
      if (awready_i) begin
        awready_i = 1'b0;
        aw_got = 1'b1;
        aw_wait = next_stall();
      end else if (awvalid_o) begin
        if (aw_wait == 0) begin
          awready_i = 1'b1;
          aw_addr_q = aw_o.addr;
        end else begin
          aw_wait = aw_wait - 1;
        end
      end
      if (wready_i) begin
        wready_i = 1'b0;
        w_got = 1'b1;
        w_wait = next_stall();
      end else if (wvalid_o) begin
        if (w_wait == 0) begin
          wready_i = 1'b1;
          w_data_q = w_o.data;
          w_strb_q = w_o.strb;
        end else begin
          w_wait = w_wait - 1;
        end
      end
      if (bvalid_i) begin
        bvalid_i = 1'b0;
        b_wait = next_stall();
      end else if (aw_got && w_got) begin
        if (b_wait == 0) begin
          for (int b = 0; b < 4; b++) begin
            if (w_strb_q[b]) begin
              mem[aw_addr_q[7:2]][b*8 +: 8] = w_data_q[b*8 +: 8];
            end
          end
          bvalid_i = 1'b1;
          aw_got = 1'b0;
          w_got = 1'b0;
        end else begin
          b_wait = b_wait - 1;
        end
      end
      if (arready_i) begin
        arready_i = 1'b0;
        ar_got = 1'b1;
        ar_wait = next_stall();
      end else if (arvalid_o) begin
        if (ar_wait == 0) begin
          arready_i = 1'b1;
          ar_addr_q = ar_o.addr;
        end else begin
          ar_wait = ar_wait - 1;
        end
      end
      if (rvalid_i) begin
        rvalid_i = 1'b0;
        r_wait = next_stall();
      end else if (ar_got) begin
        if (r_wait == 0) begin
          rdata_i = mem[ar_addr_q[7:2]];
          rvalid_i = 1'b1;
          ar_got = 1'b0;
        end else begin
          r_wait = r_wait - 1;
        end
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    value_errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    protocol_errors++;
  endtask

  // RV32I result rules
  // OP opcodes have bit 5 set and take rs2
  function automatic logic [31:0] alu_model(input exu_pkg::exu_in_t ins);
    logic [31:0] a;
    logic [31:0] b;
    a = ins.rdata1;
    b = ins.inst[5] ? ins.rdata2 : ins.imm;
    case (ins.alu_op)
      exu_pkg::ALU_ADD:   return a + b;
      exu_pkg::ALU_SUB:   return a - b;
      exu_pkg::ALU_SLL:   return a << b[4:0];
      exu_pkg::ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      exu_pkg::ALU_XOR:   return a ^ b;
      exu_pkg::ALU_SRL:   return a >> b[4:0];
      exu_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
      exu_pkg::ALU_OR:    return a | b;
      exu_pkg::ALU_AND:   return a & b;
      exu_pkg::ALU_LUI:   return ins.imm;
      exu_pkg::ALU_AUIPC: return ins.pc + ins.imm;
      exu_pkg::ALU_LINK:  return ins.pc + 32'd4;
      default:            return 32'd0;
    endcase
  endfunction

  // Returns at the falling edge after acceptance
  task automatic issue(input exu_pkg::exu_in_t ins);
    @(negedge clock);
    in_i = ins;
    in_valid_i = 1'b1;
    #1;
    while (!in_ready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    in_valid_i = 1'b0;
  endtask

  task automatic await_result(output exu_pkg::exu_wb_t wb, output exu_pkg::exu_csr_wb_t csr);
    while (!out_valid_o) @(negedge clock);
    wb = wb_o;
    csr = csr_o;
    @(negedge clock);
  endtask

  task automatic reset_state();
    #1;
    if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", out_valid_o, 0);
    if (awvalid_o !== 1'b0) report_mismatch("awvalid_o", awvalid_o, 0);
    if (wvalid_o !== 1'b0) report_mismatch("wvalid_o", wvalid_o, 0);
    if (bready_o !== 1'b0) report_mismatch("bready_o", bready_o, 0);
    if (arvalid_o !== 1'b0) report_mismatch("arvalid_o", arvalid_o, 0);
    if (rready_o !== 1'b0) report_mismatch("rready_o", rready_o, 0);
    if (in_ready_o !== 1'b1) report_mismatch("in_ready_o", in_ready_o, 1);
  endtask

  // All ALU ops in register then immediate form at one per cycle
  task automatic alu_stream();
    exu_pkg::exu_in_t ins;
    exu_pkg::exu_in_t prev;
    logic [31:0]      rnd;
    for (int i = 0; i <= 26; i++) begin
      @(negedge clock);
      if (i > 0) begin
        if (out_valid_o !== 1'b1) note_failure("ALU result not valid one cycle after acceptance");
        if (wb_o.alu_result !== alu_model(prev)) begin
          report_mismatch("wb_o.alu_result", wb_o.alu_result, alu_model(prev));
        end
        if (wb_o.pc !== prev.pc) report_mismatch("wb_o.pc", wb_o.pc, prev.pc);
        if (wb_o.inst !== prev.inst) report_mismatch("wb_o.inst", wb_o.inst, prev.inst);
        if (wb_o.wsel !== 1'b0) report_mismatch("wb_o.wsel", wb_o.wsel, 0);
        if (wb_o.wena !== prev.wena) report_mismatch("wb_o.wena", wb_o.wena, prev.wena);
        if (wb_o.waddr !== prev.waddr) report_mismatch("wb_o.waddr", wb_o.waddr, prev.waddr);
      end
      if (i < 26) begin
        rnd = next_rand();
        ins = '0;
        ins.inst_type = exu_pkg::INST_ALU;
        ins.alu_op = exu_pkg::alu_op_e'(i % 13);
        ins.inst = {rnd[31:7], (i < 13) ? 7'h33 : 7'h13};
        ins.imm = {{20{rnd[11]}}, rnd[11:0]};
        ins.rdata1 = next_rand();
        ins.rdata2 = next_rand();
        ins.pc = {rnd[31:2], 2'b00};
        ins.wena = rnd[0];
        ins.waddr = 5'(i);
        in_i = ins;
        in_valid_i = 1'b1;
        prev = ins;
        #1;
        if (in_ready_o !== 1'b1) note_failure("Stage not ready during the ALU stream");
      end else begin
        in_valid_i = 1'b0;
      end
    end
  endtask

  task automatic csr_updates();
    exu_pkg::exu_in_t     ins;
    exu_pkg::exu_wb_t     wb;
    exu_pkg::exu_csr_wb_t csr;
    logic [31:0]          src;
    logic [31:0]          expected;
    for (int i = 0; i < 6; i++) begin
      ins = '0;
      ins.inst_type = exu_pkg::INST_CSR;
      ins.csr_op = exu_pkg::csr_op_e'(i);
      ins.inst = 32'h0000_0073;
      ins.wena = 1'b1;
      ins.waddr = 5'(i + 3);
      ins.csr_wena = i[0];
      ins.csr_waddr = 12'(next_rand() >> 20);
      ins.imm = next_rand();
      ins.rdata1 = next_rand();
      ins.csr_rdata = next_rand();
      src = (i >= 3) ? {27'd0, ins.imm[4:0]} : ins.rdata1;
      case (i % 3)
        0:       expected = src;
        1:       expected = ins.csr_rdata | src;
        default: expected = ins.csr_rdata & ~src;
      endcase
      issue(ins);
      await_result(wb, csr);
      if (wb.alu_result !== ins.csr_rdata) begin
        report_mismatch("wb_o.alu_result", wb.alu_result, ins.csr_rdata);
      end
      if (csr.csr_wdata !== expected) report_mismatch("csr_o.csr_wdata", csr.csr_wdata, expected);
      if (csr.csr_op !== ins.csr_op) report_mismatch("csr_o.csr_op", csr.csr_op, ins.csr_op);
      if (csr.csr_wena !== ins.csr_wena) begin
        report_mismatch("csr_o.csr_wena", csr.csr_wena, ins.csr_wena);
      end
      if (csr.csr_waddr !== ins.csr_waddr) begin
        report_mismatch("csr_o.csr_waddr", csr.csr_waddr, ins.csr_waddr);
      end
    end
  endtask

  task automatic store_lanes();
    exu_pkg::exu_in_t     ins;
    exu_pkg::exu_wb_t     wb;
    exu_pkg::exu_csr_wb_t csr;
    logic [31:0]          addr;
    logic [31:0]          expected;
    logic [31:0]          below;
    logic [31:0]          above;
    logic [3:0]           strb_exp;
    int                   off;
    int                   idx;
    for (int k = 0; k < 7; k++) begin
      ins = '0;
      ins.inst_type = exu_pkg::INST_STORE;
      if (k < 4) begin
        ins.lsu_op = exu_pkg::LSU_SB;
        off = k;
        strb_exp = 4'b0001 << off;
      end else if (k < 6) begin
        ins.lsu_op = exu_pkg::LSU_SH;
        off = (k - 4) * 2;
        strb_exp = 4'b0011 << off;
      end else begin
        ins.lsu_op = exu_pkg::LSU_SW;
        off = 0;
        strb_exp = 4'b1111;
      end
      idx = 8 + 3 * k;
      addr = idx * 4 + off;
      ins.imm = {{20{k[0]}}, 12'(next_rand() >> 20)};
      ins.rdata1 = addr - ins.imm;
      ins.rdata2 = next_rand();
      expected = mem[idx];
      below = mem[idx - 1];
      above = mem[idx + 1];
      for (int b = 0; b < 4; b++) begin
        if (strb_exp[b]) expected[b*8 +: 8] = ins.rdata2[(b - off)*8 +: 8];
      end
      issue(ins);
      await_result(wb, csr);
      if (aw_addr_q !== {addr[31:2], 2'b00}) begin
        report_mismatch("aw_o.addr", aw_addr_q, {addr[31:2], 2'b00});
      end
      if (w_strb_q !== strb_exp) report_mismatch("w_o.strb", w_strb_q, strb_exp);
      if (mem[idx] !== expected) report_mismatch("mem word", mem[idx], expected);
      if (mem[idx - 1] !== below) report_mismatch("mem word below", mem[idx - 1], below);
      if (mem[idx + 1] !== above) report_mismatch("mem word above", mem[idx + 1], above);
    end
  endtask

  task automatic load_extension();
    exu_pkg::exu_in_t     ins;
    exu_pkg::exu_wb_t     wb;
    exu_pkg::exu_csr_wb_t csr;
    logic [31:0]          shifted;
    logic [31:0]          expected;
    int                   off;
    int                   idx;
    for (int k = 0; k < 13; k++) begin
      ins = '0;
      ins.inst_type = exu_pkg::INST_LOAD;
      if (k < 8) begin
        ins.lsu_op = (k < 4) ? exu_pkg::LSU_LB : exu_pkg::LSU_LBU;
        off = k % 4;
      end else if (k < 12) begin
        ins.lsu_op = (k < 10) ? exu_pkg::LSU_LH : exu_pkg::LSU_LHU;
        off = (k % 2) * 2;
      end else begin
        ins.lsu_op = exu_pkg::LSU_LW;
        off = 0;
      end
      idx = 40 + k;
      ins.wsel = 1'b1;
      ins.wena = 1'b1;
      ins.waddr = 5'(next_rand() >> 27);
      ins.imm = 32'(off);
      ins.rdata1 = idx * 4;
      shifted = mem[idx] >> (off * 8);
      case (ins.lsu_op)
        exu_pkg::LSU_LB:  expected = {{24{shifted[7]}}, shifted[7:0]};
        exu_pkg::LSU_LBU: expected = {24'd0, shifted[7:0]};
        exu_pkg::LSU_LH:  expected = {{16{shifted[15]}}, shifted[15:0]};
        exu_pkg::LSU_LHU: expected = {16'd0, shifted[15:0]};
        default:          expected = mem[idx];
      endcase
      issue(ins);
      await_result(wb, csr);
      if (ar_addr_q !== idx * 4) report_mismatch("ar_o.addr", ar_addr_q, idx * 4);
      if (wb.mem_result !== expected) report_mismatch("wb_o.mem_result", wb.mem_result, expected);
      if (wb.wsel !== 1'b1) report_mismatch("wb_o.wsel", wb.wsel, 1);
      if (wb.waddr !== ins.waddr) report_mismatch("wb_o.waddr", wb.waddr, ins.waddr);
    end
  endtask

  task automatic output_stall();
    exu_pkg::exu_in_t first;
    exu_pkg::exu_in_t second;
    exu_pkg::exu_wb_t held;
    first = '0;
    first.inst_type = exu_pkg::INST_ALU;
    first.alu_op = exu_pkg::ALU_ADD;
    first.inst = 32'h0000_0033;
    first.rdata1 = next_rand();
    first.rdata2 = next_rand();
    first.pc = 32'h0000_0100;
    first.wena = 1'b1;
    first.waddr = 5'd7;
    second = first;
    second.alu_op = exu_pkg::ALU_XOR;
    second.pc = 32'h0000_0104;
    second.rdata2 = next_rand();
    issue(first);
    out_ready_i = 1'b0;
    held = wb_o;
    if (held.alu_result !== alu_model(first)) begin
      report_mismatch("wb_o.alu_result", held.alu_result, alu_model(first));
    end
    in_i = second;
    in_valid_i = 1'b1;
    repeat (6) begin
      #1;
      if (in_ready_o !== 1'b0) note_failure("Stage ready while its output is stalled");
      if (out_valid_o !== 1'b1) note_failure("Result dropped while output is stalled");
      if (wb_o.alu_result !== held.alu_result) begin
        report_mismatch("wb_o.alu_result", wb_o.alu_result, held.alu_result);
      end
      if (wb_o.pc !== held.pc) report_mismatch("wb_o.pc", wb_o.pc, held.pc);
      @(negedge clock);
    end
    out_ready_i = 1'b1;
    #1;
    if (in_ready_o !== 1'b1) note_failure("Stage not ready on the output handshake");
    @(negedge clock);
    in_valid_i = 1'b0;
    if (wb_o.pc !== second.pc) report_mismatch("wb_o.pc", wb_o.pc, second.pc);
    if (wb_o.alu_result !== alu_model(second)) begin
      report_mismatch("wb_o.alu_result", wb_o.alu_result, alu_model(second));
    end
    @(negedge clock);
  endtask

  initial begin
    rst_n_i = 1'b0;
    in_valid_i = 1'b0;
    in_i = '0;
    out_ready_i = 1'b1;
    awready_i = 1'b0;
    wready_i = 1'b0;
    bvalid_i = 1'b0;
    bresp_i = '0;
    arready_i = 1'b0;
    rvalid_i = 1'b0;
    rdata_i = '0;
    rresp_i = '0;
    op_seed = SEED;
    stall_seed = SEED;
    {aw_wait, w_wait, b_wait, ar_wait, r_wait} = '0;
    {aw_got, w_got, ar_got} = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h5a3c_96e1 ^ (i * 32'h0101_0101);
    end
    repeat (RESET_CYCLES) @(negedge clock);
    rst_n_i = 1'b1;
    reset_state();
    alu_stream();
    csr_updates();
    store_lanes();
    load_extension();
    output_stall();
    repeat (2) @(negedge clock);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_params.svh"

module execute (
  input  wire                   clock,
  input  wire                   rst_n_i,

  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  exu_pkg::exu_in_t      in_i,

  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output exu_pkg::exu_wb_t      wb_o,
  output exu_pkg::exu_csr_wb_t  csr_o,

  // AXI4-Lite write
  output logic                  awvalid_o,
  input  wire                   awready_i,
  output exu_pkg::axi_aw_t      aw_o,
  output logic                  wvalid_o,
  input  wire                   wready_i,
  output exu_pkg::axi_w_t       w_o,
  input  wire                   bvalid_i,
  output logic                  bready_o,
  input  wire [`EXU_RESP_W-1:0] bresp_i,

  // AXI4-Lite read
  output logic                  arvalid_o,
  input  wire                   arready_i,
  output exu_pkg::axi_ar_t      ar_o,
  input  wire                   rvalid_i,
  output logic                  rready_o,
  input  wire [`EXU_XLEN-1:0]   rdata_i,
  input  wire [`EXU_RESP_W-1:0] rresp_i
);

  logic                 capture;
  logic                 rdata_we;
  exu_pkg::exu_in_t     ex_q;
  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic [`EXU_XLEN-1:0] mem_result;

  execute_controller controller (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .inst_type_i (in_i.inst_type),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .capture_o   (capture),
    .rdata_we_o  (rdata_we),
    .awready_i   (awready_i),
    .awvalid_o   (awvalid_o),
    .wready_i    (wready_i),
    .wvalid_o    (wvalid_o),
    .bvalid_i    (bvalid_i),
    .bready_o    (bready_o),
    .arready_i   (arready_i),
    .arvalid_o   (arvalid_o),
    .rvalid_i    (rvalid_i),
    .rready_o    (rready_o)
  );

  execute_reg reg0 (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .capture_i (capture),
    .in_i      (in_i),
    .q_o       (ex_q)
  );

  fu fu0 (
    .in_i         (ex_q),
    .alu_result_o (alu_result),
    .csr_wdata_o  (csr_wdata)
  );

  lsu lsu0 (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .rdata_we_i   (rdata_we),
    .in_i         (ex_q),
    .rdata_i      (rdata_i),
    .aw_o         (aw_o),
    .w_o          (w_o),
    .ar_o         (ar_o),
    .mem_result_o (mem_result)
  );

  assign wb_o.pc         = ex_q.pc;
  assign wb_o.inst       = ex_q.inst;
  assign wb_o.wsel       = ex_q.wsel;
  assign wb_o.wena       = ex_q.wena;
  assign wb_o.waddr      = ex_q.waddr;
  assign wb_o.alu_result = alu_result;
  assign wb_o.mem_result = mem_result;

  assign csr_o.csr_op    = ex_q.csr_op;
  assign csr_o.csr_wena  = ex_q.csr_wena;
  assign csr_o.csr_waddr = ex_q.csr_waddr;
  assign csr_o.csr_wdata = csr_wdata;

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_params.svh"

module lsu (
  input  wire                  clock,
  input  wire                  rst_n_i,

  input  wire                  rdata_we_i,
  input  exu_pkg::exu_in_t     in_i,
  input  wire [`EXU_XLEN-1:0]  rdata_i,

  output exu_pkg::axi_aw_t     aw_o,
  output exu_pkg::axi_w_t      w_o,
  output exu_pkg::axi_ar_t     ar_o,
  output logic [`EXU_XLEN-1:0] mem_result_o
);

  logic [`EXU_XLEN-1:0]   addr;
  logic [`EXU_XLEN-1:0]   word_addr;
  logic [1:0]             offset;
  logic [4:0]             lane_shift;
  logic [`EXU_XLEN-1:0]   rdata_q;
  logic [`EXU_XLEN-1:0]   ld_word;
  logic [`EXU_STRB_W-1:0] strb;

  assign addr       = in_i.rdata1 + in_i.imm;
  assign offset     = addr[1:0];
  assign lane_shift = {offset, 3'b000};
  assign word_addr  = {addr[`EXU_XLEN-1:2], 2'b00};

  assign aw_o.addr = word_addr;
  assign ar_o.addr = word_addr;

  // Store data moves into the addressed lanes
  always_comb begin
    case (in_i.lsu_op)
      exu_pkg::LSU_SB: strb = 4'b0001 << offset;
      exu_pkg::LSU_SH: strb = 4'b0011 << offset;
      default:         strb = 4'b1111;
    endcase
  end

  assign w_o.data = in_i.rdata2 << lane_shift;
  assign w_o.strb = strb;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rdata_we_i) begin
      rdata_q <= rdata_i;
    end
  end

  // Addressed byte or halfword lands in bit 0
  assign ld_word = rdata_q >> lane_shift;

  always_comb begin
    case (in_i.lsu_op)
      exu_pkg::LSU_LB:  mem_result_o = {{(`EXU_XLEN-8){ld_word[7]}}, ld_word[7:0]};
      exu_pkg::LSU_LH:  mem_result_o = {{(`EXU_XLEN-16){ld_word[15]}}, ld_word[15:0]};
      exu_pkg::LSU_LBU: mem_result_o = {{(`EXU_XLEN-8){1'b0}}, ld_word[7:0]};
      exu_pkg::LSU_LHU: mem_result_o = {{(`EXU_XLEN-16){1'b0}}, ld_word[15:0]};
      default:          mem_result_o = rdata_q;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/fu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_params.svh"

module fu (
  input  exu_pkg::exu_in_t     in_i,

  output logic [`EXU_XLEN-1:0] alu_result_o,
  output logic [`EXU_XLEN-1:0] csr_wdata_o
);

  localparam logic [`EXU_XLEN-1:0] PC_STEP = 4;

  logic                 use_imm;
  logic                 csr_imm_form;
  logic [`EXU_XLEN-1:0] op_a;
  logic [`EXU_XLEN-1:0] op_b;
  logic [4:0]           shamt;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_src;

  // OP-IMM has opcode bit 5 clear, OP has it set
  assign use_imm = ~in_i.inst[5];
  assign op_a    = in_i.rdata1;
  assign op_b    = use_imm ? in_i.imm : in_i.rdata2;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (in_i.alu_op)
      exu_pkg::ALU_ADD:   alu_res = op_a + op_b;
      exu_pkg::ALU_SUB:   alu_res = op_a - op_b;
      exu_pkg::ALU_SLL:   alu_res = op_a << shamt;
      exu_pkg::ALU_SLT:   alu_res = {{(`EXU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      exu_pkg::ALU_SLTU:  alu_res = {{(`EXU_XLEN-1){1'b0}}, op_a < op_b};
      exu_pkg::ALU_XOR:   alu_res = op_a ^ op_b;
      exu_pkg::ALU_SRL:   alu_res = op_a >> shamt;
      exu_pkg::ALU_SRA:   alu_res = $unsigned($signed(op_a) >>> shamt);
      exu_pkg::ALU_OR:    alu_res = op_a | op_b;
      exu_pkg::ALU_AND:   alu_res = op_a & op_b;
      exu_pkg::ALU_LUI:   alu_res = in_i.imm;
      exu_pkg::ALU_AUIPC: alu_res = in_i.pc + in_i.imm;
      exu_pkg::ALU_LINK:  alu_res = in_i.pc + PC_STEP;
      default:            alu_res = '0;
    endcase
  end

  // Immediate forms take a 5 bit zero-extended source
  assign csr_imm_form = (in_i.csr_op == exu_pkg::CSR_RWI) |
                        (in_i.csr_op == exu_pkg::CSR_RSI) |
                        (in_i.csr_op == exu_pkg::CSR_RCI);
  assign csr_src = csr_imm_form ? {{(`EXU_XLEN-5){1'b0}}, in_i.imm[4:0]} : in_i.rdata1;

  always_comb begin
    case (in_i.csr_op)
      exu_pkg::CSR_RW, exu_pkg::CSR_RWI: csr_wdata_o = csr_src;
      exu_pkg::CSR_RS, exu_pkg::CSR_RSI: csr_wdata_o = in_i.csr_rdata | csr_src;
      exu_pkg::CSR_RC, exu_pkg::CSR_RCI: csr_wdata_o = in_i.csr_rdata & ~csr_src;
      default:                           csr_wdata_o = in_i.csr_rdata;
    endcase
  end

  // CSR instructions return the old CSR value to rd
  assign alu_result_o = (in_i.inst_type == exu_pkg::INST_CSR) ? in_i.csr_rdata : alu_res;

endmodule

`default_nettype wire

//--- hw/execute_reg.sv
`timescale 1ns/1ns
`default_nettype none

module execute_reg (
  input  wire              clock,
  input  wire              rst_n_i,

  input  wire              capture_i,
  input  exu_pkg::exu_in_t in_i,

  output exu_pkg::exu_in_t q_o
);

  exu_pkg::exu_in_t data_q;

  // Cleared bundle has both write enables low
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_q <= '0;
    end else if (capture_i) begin
      data_q <= in_i;
    end
  end

  assign q_o = data_q;

endmodule

`default_nettype wire

//--- hw/execute_controller.sv
`timescale 1ns/1ns
`default_nettype none

module execute_controller (
  input  wire                 clock,
  input  wire                 rst_n_i,

  input  wire                 in_valid_i,
  output logic                in_ready_o,
  input  exu_pkg::inst_type_e inst_type_i,

  output logic                out_valid_o,
  input  wire                 out_ready_i,

  output logic                capture_o,
  output logic                rdata_we_o,

  input  wire                 awready_i,
  output logic                awvalid_o,
  input  wire                 wready_i,
  output logic                wvalid_o,
  input  wire                 bvalid_i,
  output logic                bready_o,
  input  wire                 arready_i,
  output logic                arvalid_o,
  input  wire                 rvalid_i,
  output logic                rready_o
);

  typedef enum logic [2:0] {
    S_IDLE, S_DONE, S_LD_ADDR, S_LD_DATA, S_ST_REQ, S_ST_RESP
  } state_e;

  state_e state_q, state_d;
  logic   aw_done_q, aw_done_d;
  logic   w_done_q, w_done_d;
  logic   aw_ok, w_ok;

  // Accept while idle or while the result leaves this cycle
  assign in_ready_o  = (state_q == S_IDLE) | ((state_q == S_DONE) & out_ready_i);
  assign capture_o   = in_valid_i & in_ready_o;
  assign out_valid_o = (state_q == S_DONE);

  assign arvalid_o  = (state_q == S_LD_ADDR);
  assign rready_o   = (state_q == S_LD_DATA);
  assign rdata_we_o = rready_o & rvalid_i;

  // AW and W complete independently
  assign awvalid_o = (state_q == S_ST_REQ) & ~aw_done_q;
  assign wvalid_o  = (state_q == S_ST_REQ) & ~w_done_q;
  assign aw_ok     = aw_done_q | (awvalid_o & awready_i);
  assign w_ok      = w_done_q | (wvalid_o & wready_i);
  assign bready_o  = (state_q == S_ST_RESP);

  always_comb begin
    state_d   = state_q;
    aw_done_d = 1'b0;
    w_done_d  = 1'b0;
    case (state_q)
      S_IDLE, S_DONE: begin
        if (capture_o) begin
          case (inst_type_i)
            exu_pkg::INST_LOAD:  state_d = S_LD_ADDR;
            exu_pkg::INST_STORE: state_d = S_ST_REQ;
            default:             state_d = S_DONE;
          endcase
        end else if ((state_q == S_DONE) && out_ready_i) begin
          state_d = S_IDLE;
        end
      end
      S_LD_ADDR: begin
        if (arready_i) begin
          state_d = S_LD_DATA;
        end
      end
      S_LD_DATA: begin
        if (rvalid_i) begin
          state_d = S_DONE;
        end
      end
      S_ST_REQ: begin
        if (aw_ok && w_ok) begin
          state_d = S_ST_RESP;
        end else begin
          aw_done_d = aw_ok;
          w_done_d  = w_ok;
        end
      end
      S_ST_RESP: begin
        if (bvalid_i) begin
          state_d = S_DONE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/exu_pkg.sv
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

  typedef enum logic [1:0] {
    INST_ALU   = 2'd0,
    INST_LOAD  = 2'd1,
    INST_STORE = 2'd2,
    INST_CSR   = 2'd3
  } inst_type_e;

  // Link gives pc + 4
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
    ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC, ALU_LINK
  } alu_op_e;

  typedef enum logic [2:0] {
    LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
  } lsu_op_e;

  typedef enum logic [2:0] {
    CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI
  } csr_op_e;

  typedef struct packed {
    inst_type_e                  inst_type;
    alu_op_e                     alu_op;
    lsu_op_e                     lsu_op;
    csr_op_e                     csr_op;
    logic                        wsel;
    logic                        wena;
    logic [`EXU_REG_ADDR_W-1:0]  waddr;
    logic                        csr_wena;
    logic [`EXU_CSR_ADDR_W-1:0]  csr_waddr;
    logic [`EXU_XLEN-1:0]        pc;
    logic [`EXU_XLEN-1:0]        inst;
    logic [`EXU_XLEN-1:0]        imm;
    logic [`EXU_XLEN-1:0]        rdata1;
    logic [`EXU_XLEN-1:0]        rdata2;
    logic [`EXU_XLEN-1:0]        csr_rdata;
  } exu_in_t;

  // wsel picks mem_result for the register write
  typedef struct packed {
    logic [`EXU_XLEN-1:0]        pc;
    logic [`EXU_XLEN-1:0]        inst;
    logic                        wsel;
    logic                        wena;
    logic [`EXU_REG_ADDR_W-1:0]  waddr;
    logic [`EXU_XLEN-1:0]        alu_result;
    logic [`EXU_XLEN-1:0]        mem_result;
  } exu_wb_t;

  typedef struct packed {
    csr_op_e                     csr_op;
    logic                        csr_wena;
    logic [`EXU_CSR_ADDR_W-1:0]  csr_waddr;
    logic [`EXU_XLEN-1:0]        csr_wdata;
  } exu_csr_wb_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]        addr;
  } axi_aw_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]        data;
    logic [`EXU_STRB_W-1:0]      strb;
  } axi_w_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]        addr;
  } axi_ar_t;

endpackage

`default_nettype wire

//--- hw/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Data and address width
`define EXU_XLEN 32

// Byte lanes per data word
`define EXU_STRB_W (`EXU_XLEN / 8)

// Register file index
`define EXU_REG_ADDR_W 5

// CSR address space
`define EXU_CSR_ADDR_W 12

// Bus response code
`define EXU_RESP_W 2

`endif
